/* src/parserPkg.sv */
package parserPkg;

	//////////////////////////////////////////////////
	// geometry
	localparam int NUM_BANKS  = 16;
	localparam int WIN        = 4;                 // window edge, groups and lanes
	localparam int IMG_ROWS   = 8;
	localparam int IMG_COLS   = 8;
	localparam int WIN_ROWS   = IMG_ROWS / 2;      // stride 2
	localparam int WIN_COLS   = IMG_COLS / 2;
	localparam int ADDR_W     = 9;
	localparam int WORD_W     = 128;
	localparam int WORD_BYTES = WORD_W / 8;        // byte channels per word
	localparam int HALF_BYTES = 8;
	localparam int HALF_W     = HALF_BYTES * 8;
	localparam int NUM_HALVES = WORD_W / HALF_W;
	// pixel coordinate plus one, up to image edge plus two
	localparam int COORD_W    = $clog2((IMG_ROWS > IMG_COLS ? IMG_ROWS : IMG_COLS) + 3);

	//////////////////////////////////////////////////
	// timing
	localparam int WINDOW_CYCLES = 8;
	localparam int ROW_GAP       = 4;              // idle cycles after each window row
	localparam int PHASE_W       = $clog2(WINDOW_CYCLES);
	localparam int GAP_W         = $clog2(ROW_GAP + 1);

	localparam logic [PHASE_W-1:0] PH_ADDR    = PHASE_W'(0);
	localparam logic [PHASE_W-1:0] PH_CAPTURE = PHASE_W'(2);  // bram data valid here
	localparam logic [PHASE_W-1:0] PH_MAC_LO  = PHASE_W'(3);
	localparam logic [PHASE_W-1:0] PH_MAC_HI  = PHASE_W'(4);

	// sequencer states
	localparam int STATE_W = 2;
	localparam logic [STATE_W-1:0] ST_IDLE   = 2'd0;
	localparam logic [STATE_W-1:0] ST_WINDOW = 2'd1;
	localparam logic [STATE_W-1:0] ST_ROWGAP = 2'd2;

	//////////////////////////////////////////////////
	// bank word, seen as byte channels or as mac halves
	typedef union packed {
		logic [WORD_BYTES-1:0][7:0]        bytes;
		logic [NUM_HALVES-1:0][HALF_W-1:0] halves;
	} bankWord_t;

endpackage

/* src/windowSequencer.sv */
`timescale 1ns/10ps

module windowSequencer import parserPkg::*; (
	input  logic       clk,
	input  logic       rstn,
	input  logic       start,
	output logic [1:0] winRow,
	output logic [1:0] winCol,
	output logic       addrStrobe,
	output logic       captureStrobe,
	output logic       macVld,
	output logic       macHalf
);

	logic [STATE_W-1:0] state;
	logic [PHASE_W-1:0] phase;
	logic [GAP_W-1:0]   gapCnt;
	logic               inWindow;
	logic               lastPhase;
	logic               lastCol;
	logic               lastRow;
	logic               lastGap;

	assign inWindow  = start && (state == ST_WINDOW);
	assign lastPhase = (phase == PHASE_W'(WINDOW_CYCLES - 1));
	assign lastCol   = (winCol == 2'(WIN_COLS - 1));
	assign lastRow   = (winRow == 2'(WIN_ROWS - 1));
	assign lastGap   = (gapCnt == GAP_W'(ROW_GAP - 1));

	//////////////////////////////////////////////////
	// frame fsm, frozen while start is low
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state  <= ST_IDLE;
			phase  <= '0;
			gapCnt <= '0;
			winRow <= '0;
			winCol <= '0;
		end else if (start) begin
			case (state)
				ST_IDLE: begin
					state <= ST_WINDOW;  // window (0,0) next cycle
					phase <= '0;
				end
				ST_WINDOW: begin
					phase <= phase + 1'b1;
					if (lastPhase) begin
						phase  <= '0;
						winCol <= winCol + 1'b1;
						if (lastCol) begin
							winCol <= '0;
							winRow <= winRow + 1'b1;
							gapCnt <= '0;
							state  <= ST_ROWGAP;
							if (lastRow) begin
								winRow <= '0;
								state  <= ST_IDLE;  // frame done
							end
						end
					end
				end
				ST_ROWGAP: begin
					gapCnt <= gapCnt + 1'b1;
					if (lastGap) begin
						gapCnt <= '0;
						state  <= ST_WINDOW;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////
	// phase strobes
	assign addrStrobe    = inWindow && (phase == PH_ADDR);
	assign captureStrobe = inWindow && (phase == PH_CAPTURE);
	assign macVld        = inWindow && ((phase == PH_MAC_LO) || (phase == PH_MAC_HI));
	assign macHalf       = inWindow && (phase == PH_MAC_HI);  // upper bytes second

endmodule

/* src/bankAddrGen.sv */
`timescale 1ns/10ps

module bankAddrGen import parserPkg::*; (
	input  logic                 clk,
	input  logic                 rstn,
	input  logic [1:0]           winRow,
	input  logic [1:0]           winCol,
	input  logic                 addrStrobe,
	output logic [NUM_BANKS-1:0] cs,
	output logic [ADDR_W-1:0]    addr [NUM_BANKS]
);

	logic [NUM_BANKS-1:0] csNext;
	logic [ADDR_W-1:0]    addrNext [NUM_BANKS];

	// Image coordinate plus one of the window pixel whose coordinate is sel mod 4.
	// The window starts at 2*win-1, so the offset into the window is (sel+1-2*win) mod 4.
	function automatic logic [COORD_W-1:0] pixelPos(input logic [1:0] win,
	                                                input logic [1:0] sel);
		logic [1:0] offs;
		offs = sel + 2'd1 - 2'({win, 1'b0});
		return COORD_W'({win, 1'b0}) + COORD_W'(offs);
	endfunction

	//////////////////////////////////////////////////
	// one pixel per bank, group by row and lane by column
	for (genvar b = 0; b < NUM_BANKS; b++) begin : gBank
		logic [COORD_W-1:0] yPos;
		logic [COORD_W-1:0] xPos;
		logic               rowIn;
		logic               colIn;

		assign yPos  = pixelPos(winRow, 2'(b / WIN));
		assign xPos  = pixelPos(winCol, 2'(b % WIN));
		assign rowIn = (yPos != '0) && (yPos <= COORD_W'(IMG_ROWS));  // zero is row -1
		assign colIn = (xPos != '0) && (xPos <= COORD_W'(IMG_COLS));

		assign csNext[b]   = rowIn && colIn;
		assign addrNext[b] = csNext[b] ?
			ADDR_W'(((yPos - 1'b1) / WIN) * (IMG_COLS / WIN) + (xPos - 1'b1) / WIN) : '0;
	end

	//////////////////////////////////////////////////
	// held from phase 1 until the next window
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			cs <= '0;
			for (int b = 0; b < NUM_BANKS; b++) begin
				addr[b] <= '0;
			end
		end else if (addrStrobe) begin
			cs <= csNext;
			for (int b = 0; b < NUM_BANKS; b++) begin
				addr[b] <= addrNext[b];
			end
		end
	end

endmodule

/* src/windowAssembler.sv */
`timescale 1ns/10ps

module windowAssembler import parserPkg::*; (
	input  logic                       clk,
	input  logic                       rstn,
	input  bankWord_t                  bankData [NUM_BANKS],
	input  logic [NUM_BANKS-1:0]       cs,
	input  logic [1:0]                 winRow,
	input  logic [1:0]                 winCol,
	input  logic                       captureStrobe,
	input  logic                       macHalf,
	output logic [HALF_BYTES-1:0][7:0] din [NUM_BANKS]
);

	bankWord_t  words [NUM_BANKS];  // indexed by bank
	logic       rowSel;
	logic       colSel;

	//////////////////////////////////////////////////
	// capture, deselected banks become padding
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			for (int b = 0; b < NUM_BANKS; b++) begin
				words[b] <= '0;
			end
			rowSel <= 1'b0;
			colSel <= 1'b0;
		end else if (captureStrobe) begin
			for (int b = 0; b < NUM_BANKS; b++) begin
				for (int k = 0; k < WORD_BYTES; k++) begin
					words[b].bytes[k] <= cs[b] ? bankData[b].bytes[k] : 8'h00;
				end
			end
			rowSel <= winRow[0];  // only bit 0 shifts the rotation
			colSel <= winCol[0];
		end
	end

	//////////////////////////////////////////////////
	// slot 4r+c reads pixel (2*row-1+r, 2*col-1+c)
	for (genvar s = 0; s < NUM_BANKS; s++) begin : gSlot
		logic [1:0] grp;
		logic [1:0] lane;
		logic [3:0] bank;

		assign grp  = 2'({rowSel, 1'b0}) + 2'(s / WIN) - 2'd1;  // pixel row mod 4
		assign lane = 2'({colSel, 1'b0}) + 2'(s % WIN) - 2'd1;  // pixel col mod 4
		assign bank = {grp, lane};

		assign din[s] = words[bank].halves[macHalf];
	end

endmodule

/* src/dataParser.sv */
`timescale 1ns/10ps

module dataParser import parserPkg::*; (
	input  logic                       clk,
	input  logic                       rstn,
	input  logic                       start,
	input  bankWord_t                  bankData [NUM_BANKS],
	output logic [NUM_BANKS-1:0]       cs,
	output logic [ADDR_W-1:0]          addr [NUM_BANKS],
	output logic [HALF_BYTES-1:0][7:0] din [NUM_BANKS],
	output logic                       macVld
);

	logic [1:0] winRow;
	logic [1:0] winCol;
	logic       addrStrobe;
	logic       captureStrobe;
	logic       macHalf;

	//////////////////////////////////////////////////
	// window walk and phase strobes
	windowSequencer u_seq (
		.clk           (clk),
		.rstn          (rstn),
		.start         (start),
		.winRow        (winRow),
		.winCol        (winCol),
		.addrStrobe    (addrStrobe),
		.captureStrobe (captureStrobe),
		.macVld        (macVld),
		.macHalf       (macHalf)
	);

	bankAddrGen u_addr (
		.clk        (clk),
		.rstn       (rstn),
		.winRow     (winRow),
		.winCol     (winCol),
		.addrStrobe (addrStrobe),
		.cs         (cs),
		.addr       (addr)
	);

	// cs feeds back for zero padding
	windowAssembler u_asm (
		.clk           (clk),
		.rstn          (rstn),
		.bankData      (bankData),
		.cs            (cs),
		.winRow        (winRow),
		.winCol        (winCol),
		.captureStrobe (captureStrobe),
		.macHalf       (macHalf),
		.din           (din)
	);

endmodule

/* sim/windowChecker.sv */
`timescale 1ns/10ps

module windowChecker import parserPkg::*; (
	input  logic                       clk,
	input  logic                       rstn,
	input  logic                       start,
	input  logic [NUM_BANKS-1:0]       cs,
	input  logic [ADDR_W-1:0]          addr [NUM_BANKS],
	input  logic [HALF_BYTES-1:0][7:0] din [NUM_BANKS],
	input  logic                       macVld,
	input  bankWord_t                  image [IMG_ROWS*IMG_COLS],
	input  logic                       testEnd,
	input  int                         testId,
	output int                         pairCount,
	output int                         errTotal,
	output int                         testsRun,
	output int                         testsFailed
);

	localparam int NUM_CATS = 4;
	localparam int CAT_IDLE = 0;
	localparam int CAT_DATA = 1;
	localparam int CAT_ADDR = 2;
	localparam int CAT_GAP  = 3;
	localparam int WIN_GAP  = 6;  // phases 5..7 and 0..2

	int errCat [NUM_CATS];
	int errSeen [NUM_CATS];
	int wIdx;
	int gapLow;  // start-high cycles without valid
	bit started;
	bit havePrev;
	bit secondHalf;

	function automatic bit inImage(input int y, input int x);
		return (y >= 0) && (y < IMG_ROWS) && (x >= 0) && (x < IMG_COLS);
	endfunction

	// coordinate in the window span that is congruent to sel mod 4
	function automatic int pickPos(input int win, input int sel);
		int pos;
		pos = 0;
		for (int k = 0; k < WIN; k++) begin
			if ((2 * win - 1 + k + WIN) % WIN == sel) begin
				pos = 2 * win - 1 + k;
			end
		end
		return pos;
	endfunction

	function automatic int expectedGap(input int w);
		if (w == 0) begin
			return WIN_GAP + 1;  // one idle cycle between frames
		end else if (w % WIN_COLS == 0) begin
			return WIN_GAP + ROW_GAP;
		end
		return WIN_GAP;
	endfunction

	function automatic logic [NUM_CATS-1:0] testCats(input int id);
		case (id)
			1: return 4'b0001;
			2: return 4'b0010;
			3: return 4'b0100;
			4: return 4'b1000;
			default: return 4'b1111;  // random start frame
		endcase
	endfunction

	function automatic string testName(input int id);
		case (id)
			1: return "idle before start";
			2: return "frame data";
			3: return "bank cs and addr";
			4: return "valid spacing";
			default: return "random start frame";
		endcase
	endfunction

	task automatic flagError(input int cat);
		errCat[cat]++;
		errTotal++;
	endtask

	//////////////////////////////////////////////////
	// address rule
	task automatic checkAddr(input int w);
		int y;
		int x;
		logic expCs;
		logic [ADDR_W-1:0] expAddr;
		for (int b = 0; b < NUM_BANKS; b++) begin
			y = pickPos(w / WIN_COLS, b / WIN);
			x = pickPos(w % WIN_COLS, b % WIN);
			expCs = inImage(y, x);
			expAddr = expCs ? ADDR_W'((y / WIN) * (IMG_COLS / WIN) + x / WIN) : '0;
			if (cs[b] !== expCs || addr[b] !== expAddr) begin
				$display("FAILED @%0t: window %0d bank %0d cs %0b addr %0d, expected %0b %0d",
					$time, w, b, cs[b], addr[b], expCs, expAddr);
				flagError(CAT_ADDR);
			end
		end
	endtask

	//////////////////////////////////////////////////
	// slot rule
	task automatic checkSlots(input int w, input int half);
		int py;
		int px;
		bankWord_t word;
		logic [HALF_BYTES-1:0][7:0] expHalf;
		for (int s = 0; s < NUM_BANKS; s++) begin
			py = 2 * (w / WIN_COLS) - 1 + s / WIN;
			px = 2 * (w % WIN_COLS) - 1 + s % WIN;
			word = '0;
			if (inImage(py, px)) begin
				word = image[py * IMG_COLS + px];
			end
			for (int k = 0; k < HALF_BYTES; k++) begin
				expHalf[k] = word.bytes[half * HALF_BYTES + k];
			end
			if (din[s] !== expHalf) begin
				$display("FAILED @%0t: window %0d half %0d slot %0d din %h, expected %h",
					$time, w, half, s, din[s], expHalf);
				flagError(CAT_DATA);
			end
		end
	endtask

	task automatic reportTest(input int id);
		logic [NUM_CATS-1:0] cats;
		int errs;
		string verdict;
		cats = testCats(id);
		errs = 0;
		for (int c = 0; c < NUM_CATS; c++) begin
			if (cats[c]) begin
				errs += errCat[c] - errSeen[c];
				errSeen[c] = errCat[c];
			end
		end
		testsRun++;
		verdict = "ok";
		if (errs != 0) begin
			testsFailed++;
			verdict = "failed";
		end
		$display("test %0d %s: %s, %0d errors", id, testName(id), verdict, errs);
	endtask

	always @(posedge clk) begin
		if (!rstn) begin
			for (int c = 0; c < NUM_CATS; c++) begin
				errCat[c] = 0;
				errSeen[c] = 0;
			end
			{started, havePrev, secondHalf} = 3'b000;
			wIdx = 0;
			gapLow = 0;
			pairCount = 0;
			errTotal = 0;
			testsRun = 0;
			testsFailed = 0;
		end else begin
			if (!started && (cs != '0 || macVld)) begin
				$display("FAILED @%0t: cs %h macVld %0b before start", $time, cs, macVld);
				flagError(CAT_IDLE);
			end
			if (!start && macVld) begin
				$display("FAILED @%0t: macVld high while start is low", $time);
				flagError(CAT_IDLE);
			end
			if (start) begin
				started = 1'b1;
				if (macVld) begin
					if (!secondHalf) begin
						if (havePrev && gapLow != expectedGap(wIdx)) begin
							$display("FAILED @%0t: window %0d gap %0d, expected %0d",
								$time, wIdx, gapLow, expectedGap(wIdx));
							flagError(CAT_GAP);
						end
						checkAddr(wIdx);
					end
					checkSlots(wIdx, int'(secondHalf));
					if (secondHalf) begin
						wIdx = (wIdx + 1) % (WIN_ROWS * WIN_COLS);
						pairCount++;
						havePrev = 1'b1;
					end
					secondHalf = !secondHalf;
					gapLow = 0;
				end else begin
					if (secondHalf) begin
						$display("FAILED @%0t: window %0d valid pair split", $time, wIdx);
						flagError(CAT_GAP);
						secondHalf = 1'b0;
					end
					gapLow++;
				end
			end
			if (testEnd) begin
				reportTest(testId);
			end
		end
	end

endmodule

/* sim/tbTop.sv */
`timescale 1ns/10ps

module tbTop import parserPkg::*; ();

	localparam int CLK_PERIOD    = 4;
	localparam int DRIVE_DLY     = 1;
	localparam int RESET_CYCLES  = 4;
	localparam int IDLE_CYCLES   = 12;
	localparam int FRAME_TIMEOUT = 2000;  // cycles per wait
	localparam int NUM_TESTS     = 5;
	localparam int MEM_DEPTH     = 1 << ADDR_W;

	logic                       clk;
	logic                       rstn;
	logic                       start;
	bankWord_t                  bankData [NUM_BANKS] = '{default: '0};
	logic [NUM_BANKS-1:0]       cs;
	logic [ADDR_W-1:0]          addr [NUM_BANKS];
	logic [HALF_BYTES-1:0][7:0] din [NUM_BANKS];
	logic                       macVld;

	bankWord_t mem [NUM_BANKS][MEM_DEPTH];
	bankWord_t image [IMG_ROWS*IMG_COLS];  // pixel words, row major
	integer    seed = 32'h84f1fb7b;
	logic      testEnd;
	int        testId;
	int        pairCount;
	int        errTotal;
	int        testsRun;
	int        testsFailed;
	bit        timedOut;

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	//////////////////////////////////////////////////
	// bram model, one cycle read latency
	always @(posedge clk) begin
		for (int b = 0; b < NUM_BANKS; b++) begin
			bankData[b] <= mem[b][addr[b]];
		end
	end

	dataParser u_dut (
		.clk      (clk),
		.rstn     (rstn),
		.start    (start),
		.bankData (bankData),
		.cs       (cs),
		.addr     (addr),
		.din      (din),
		.macVld   (macVld)
	);

	windowChecker u_chk (
		.clk         (clk),
		.rstn        (rstn),
		.start       (start),
		.cs          (cs),
		.addr        (addr),
		.din         (din),
		.macVld      (macVld),
		.image       (image),
		.testEnd     (testEnd),
		.testId      (testId),
		.pairCount   (pairCount),
		.errTotal    (errTotal),
		.testsRun    (testsRun),
		.testsFailed (testsFailed)
	);

	task automatic nextCycle();
		@(posedge clk);
		#DRIVE_DLY;
	endtask

	// background tags every word, then the image lands by bank group and lane
	task automatic fillMemory();
		logic [WORD_W-1:0] bits;
		int y;
		int x;
		for (int b = 0; b < NUM_BANKS; b++) begin
			for (int a = 0; a < MEM_DEPTH; a++) begin
				mem[b][a] = {4{16'(a), 8'(b), 8'h3c}};
			end
		end
		for (int p = 0; p < IMG_ROWS * IMG_COLS; p++) begin
			for (int k = 0; k < 4; k++) begin
				bits[32*k +: 32] = $random(seed);
			end
			y = p / IMG_COLS;
			x = p % IMG_COLS;
			image[p] = bits;
			mem[(y % WIN) * WIN + x % WIN][(y / WIN) * (IMG_COLS / WIN) + x / WIN] = bits;
		end
	endtask

	task automatic endTest(input int id);
		testId = id;
		testEnd = 1'b1;
		nextCycle();
		testEnd = 1'b0;
	endtask

	task automatic waitPairs(input int target, input bit shuffle, output bit expired);
		int cnt;
		cnt = 0;
		while (pairCount < target && cnt < FRAME_TIMEOUT) begin
			nextCycle();
			if (shuffle) begin
				start = (($random(seed) & 3) != 0);  // high three cycles in four
			end
			cnt++;
		end
		expired = (pairCount < target);
		if (expired) begin
			$display("timeout: %0d of %0d window pairs seen", pairCount, target);
		end
	endtask

	initial begin
		rstn = 1'b0;
		start = 1'b0;
		testEnd = 1'b0;
		testId = 0;
		timedOut = 1'b0;
		fillMemory();
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DLY;
		rstn = 1'b1;
		repeat (IDLE_CYCLES) nextCycle();
		endTest(1);

		// whole frame with start held
		start = 1'b1;
		waitPairs(WIN_ROWS * WIN_COLS, 1'b0, timedOut);
		if (!timedOut) begin
			endTest(2);
			endTest(3);
			endTest(4);
			waitPairs(2 * WIN_ROWS * WIN_COLS, 1'b1, timedOut);
		end
		start = 1'b0;
		if (!timedOut) begin
			repeat (IDLE_CYCLES) nextCycle();
			endTest(5);
		end

		$display("tests run %0d of %0d, failed %0d, errors %0d",
			testsRun, NUM_TESTS, testsFailed, errTotal);
		if (!timedOut && testsRun == NUM_TESTS && testsFailed == 0 && errTotal == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

/* tb.f */
src/parserPkg.sv
src/windowSequencer.sv
src/bankAddrGen.sv
src/windowAssembler.sv
src/dataParser.sv
sim/windowChecker.sv
sim/tbTop.sv

/* run.sh */
#!/bin/sh
rm -f sim.log &&
verilator --binary --top-module tbTop -f tb.f -o tbTop &&
./obj_dir/tbTop | tee sim.log &&
grep -q "Simulation finished: PASS" sim.log &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }
